/* Bender.yml */
package:
  name: div_service

sources:
  - include_dirs:
      - src
    files:
      - src/div_arith_pkg.sv
      - src/div_bus_pkg.sv
      - src/div_array_tri.sv
      - src/div_lane.sv
      - src/req_dispatch.sv
      - src/result_arbiter.sv
      - src/result_queue.sv
      - src/div_service_top.sv
      - target: test
        include_dirs:
          - src
        files:
          - verification/div_service_assert.sv
          - verification/div_service_tb.sv

/* div_service.f */
+incdir+src
src/div_arith_pkg.sv
src/div_bus_pkg.sv
src/div_array_tri.sv
src/div_lane.sv
src/req_dispatch.sv
src/result_arbiter.sv
src/result_queue.sv
src/div_service_top.sv
verification/div_service_assert.sv
verification/div_service_tb.sv

/* src/div_arith_pkg.sv */
`default_nettype none

`include "div_service_config.svh"

package div_arith_pkg;

  typedef logic [`DIV_DIVIDEND_W-1:0] div_dividend_t;
  typedef logic [`DIV_DIVISOR_W-1:0] div_divisor_t;

  typedef struct packed {
    logic [`DIV_DIVISOR_W-1:0] quotient;
    logic [`DIV_DIVISOR_W-1:0] remainder;
  } div_quot_rem_t;

  typedef struct packed {
    logic [`DIV_DIVISOR_W-1:0] fault_code;
    logic [`DIV_DIVISOR_W-1:0] dividend_hi;
  } div_fault_t;

  // One result word, read as a fault record when the fault flag is set
  typedef union packed {
    div_quot_rem_t qr;
    div_fault_t    fault;
  } div_result_u;

  localparam logic [`DIV_DIVISOR_W-1:0] DIV_FAULT_ZERO = 'd1;

endpackage

`default_nettype wire

/* src/div_array_tri.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_service_config.svh"

module div_array_tri #(
  parameter int APPROX_DEPTH = 0
) (
  input  wire  [`DIV_DIVIDEND_W-1:0] dividend,
  input  wire  [`DIV_DIVISOR_W-1:0]  divisor,
  output logic [`DIV_DIVISOR_W-1:0]  quotient,
  output logic [`DIV_DIVISOR_W-1:0]  remainder
);

  localparam int N = `DIV_DIVISOR_W;

  // Per-cell minuend, restored output and borrow chain, indexed [row][column]
  wire [N-1:0][N-1:0] cell_x;
  wire [N-1:0][N-1:0] cell_r;
  wire [N-1:0][N:0]   cell_b;
  wire [N-1:0]        top_bit;
  wire [N-1:0]        q_bit;

  for (genvar k = 0; k < N; k++) begin : g_row
    assign cell_b[k][0] = 1'b0;

    if (k == N - 1) begin : g_first
      assign top_bit[k] = dividend[2*N-1];
      for (genvar j = 0; j < N; j++) begin : g_in
        assign cell_x[k][j] = dividend[k+j];
      end
    end else begin : g_next
      // Shift in the next dividend bit under the previous partial remainder
      assign top_bit[k]   = cell_r[k+1][N-1];
      assign cell_x[k][0] = dividend[k];
      for (genvar j = 1; j < N; j++) begin : g_in
        assign cell_x[k][j] = cell_r[k+1][j-1];
      end
    end

    assign q_bit[k] = top_bit[k] | ~cell_b[k][N];

    for (genvar j = 0; j < N; j++) begin : g_col
      wire cell_diff;

      if (k + j < APPROX_DEPTH) begin : g_approx
        // Cheap cell, difference is dropped
        assign cell_diff      = cell_x[k][j];
        assign cell_b[k][j+1] = divisor[j] & (~cell_x[k][j] | cell_b[k][j]);
      end else begin : g_exact
        assign cell_diff      = cell_x[k][j] ^ divisor[j] ^ cell_b[k][j];
        assign cell_b[k][j+1] = (~cell_x[k][j] & divisor[j]) |
                                (~(cell_x[k][j] ^ divisor[j]) & cell_b[k][j]);
      end

      assign cell_r[k][j] = q_bit[k] ? cell_diff : cell_x[k][j];
    end
  end

  assign quotient  = q_bit;
  assign remainder = cell_r[0];

endmodule

`default_nettype wire

/* src/div_bus_pkg.sv */
`default_nettype none

`include "div_service_config.svh"

package div_bus_pkg;

  // Which divider lane served a request
  typedef enum logic {
    LANE_EXACT  = 1'b0,
    LANE_APPROX = 1'b1
  } lane_id_e;

  typedef logic [`DIV_TAG_W-1:0] div_tag_t;

endpackage

`default_nettype wire

/* src/div_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_service_config.svh"

module div_lane import div_arith_pkg::*, div_bus_pkg::*; #(
  parameter int APPROX_DEPTH = 0
) (
  input  wire                clk,
  input  wire                arst_n,
  input  wire                in_valid,
  output logic               in_ready,
  input  wire div_dividend_t in_dividend,
  input  wire div_divisor_t  in_divisor,
  input  wire div_tag_t      in_tag,
  output logic               out_valid,
  input  wire                out_ready,
  output div_tag_t           out_tag,
  output logic               out_fault,
  output div_result_u        out_result
);

  logic          s1_valid;
  div_dividend_t s1_dividend;
  div_divisor_t  s1_divisor;
  div_tag_t      s1_tag;
  logic          s1_zero;
  div_result_u   s1_result;
  div_divisor_t  arr_quot;
  div_divisor_t  arr_rem;
  logic          s2_valid;
  logic          s2_advance;

  assign s2_advance = !s2_valid || out_ready;
  assign in_ready   = !s1_valid || s2_advance;
  assign s1_zero    = (s1_divisor == '0);

  div_array_tri #(
    .APPROX_DEPTH(APPROX_DEPTH)
  ) u_array (
    .dividend (s1_dividend),
    .divisor  (s1_divisor),
    .quotient (arr_quot),
    .remainder(arr_rem)
  );

  always_comb begin
    s1_result = '0;
    if (s1_zero) begin
      s1_result.fault.fault_code  = DIV_FAULT_ZERO;
      s1_result.fault.dividend_hi = s1_dividend[`DIV_DIVIDEND_W-1 -: `DIV_DIVISOR_W];
    end else begin
      s1_result.qr.quotient  = arr_quot;
      s1_result.qr.remainder = arr_rem;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (in_ready) begin
        s1_valid <= in_valid;
      end
      if (s2_advance) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      s1_dividend <= in_dividend;
      s1_divisor  <= in_divisor;
      s1_tag      <= in_tag;
    end
    if (s1_valid && s2_advance) begin
      out_tag    <= s1_tag;
      out_fault  <= s1_zero;
      out_result <= s1_result;
    end
  end

  assign out_valid = s2_valid;

endmodule

`default_nettype wire

/* src/div_service_config.svh */
`ifndef DIV_SERVICE_CONFIG_SVH
`define DIV_SERVICE_CONFIG_SVH

// Operand widths, the divisor width is also the quotient and remainder width
`define DIV_DIVIDEND_W 16
`define DIV_DIVISOR_W 8

// Anti-diagonals of approximate cells in the approximate lane
`define DIV_APPROX_DEPTH 4

// Sequence tag width
`define DIV_TAG_W 4

// Shared result queue entries
`define DIV_QUEUE_DEPTH 8

`endif

/* src/div_service_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_service_config.svh"

module div_service_top import div_arith_pkg::*, div_bus_pkg::*; (
  input  wire                clk,
  input  wire                arst_n,
  input  wire                req_valid,
  output logic               req_ready,
  input  wire                req_approx,
  input  wire div_dividend_t req_dividend,
  input  wire div_divisor_t  req_divisor,
  output logic               rsp_valid,
  input  wire                rsp_ready,
  output lane_id_e           rsp_lane,
  output div_tag_t           rsp_tag,
  output logic               rsp_fault,
  output div_result_u        rsp_result
);

  logic          exact_in_valid;
  logic          exact_in_ready;
  logic          approx_in_valid;
  logic          approx_in_ready;
  div_dividend_t lane_dividend;
  div_divisor_t  lane_divisor;
  div_tag_t      lane_tag;

  logic          exact_done_valid;
  logic          exact_done_ready;
  div_tag_t      exact_done_tag;
  logic          exact_done_fault;
  div_result_u   exact_done_result;
  logic          approx_done_valid;
  logic          approx_done_ready;
  div_tag_t      approx_done_tag;
  logic          approx_done_fault;
  div_result_u   approx_done_result;

  logic          wr_en;
  lane_id_e      wr_lane;
  div_tag_t      wr_tag;
  logic          wr_fault;
  div_result_u   wr_result;
  logic          full;

  req_dispatch u_dispatch (
    .clk          (clk),
    .arst_n       (arst_n),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_approx   (req_approx),
    .req_dividend (req_dividend),
    .req_divisor  (req_divisor),
    .exact_valid  (exact_in_valid),
    .exact_ready  (exact_in_ready),
    .approx_valid (approx_in_valid),
    .approx_ready (approx_in_ready),
    .lane_dividend(lane_dividend),
    .lane_divisor (lane_divisor),
    .lane_tag     (lane_tag)
  );

  div_lane #(
    .APPROX_DEPTH(0)
  ) u_lane_exact (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (exact_in_valid),
    .in_ready   (exact_in_ready),
    .in_dividend(lane_dividend),
    .in_divisor (lane_divisor),
    .in_tag     (lane_tag),
    .out_valid  (exact_done_valid),
    .out_ready  (exact_done_ready),
    .out_tag    (exact_done_tag),
    .out_fault  (exact_done_fault),
    .out_result (exact_done_result)
  );

  div_lane #(
    .APPROX_DEPTH(`DIV_APPROX_DEPTH)
  ) u_lane_approx (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (approx_in_valid),
    .in_ready   (approx_in_ready),
    .in_dividend(lane_dividend),
    .in_divisor (lane_divisor),
    .in_tag     (lane_tag),
    .out_valid  (approx_done_valid),
    .out_ready  (approx_done_ready),
    .out_tag    (approx_done_tag),
    .out_fault  (approx_done_fault),
    .out_result (approx_done_result)
  );

  result_arbiter u_arbiter (
    .clk          (clk),
    .arst_n       (arst_n),
    .exact_valid  (exact_done_valid),
    .exact_ready  (exact_done_ready),
    .exact_tag    (exact_done_tag),
    .exact_fault  (exact_done_fault),
    .exact_result (exact_done_result),
    .approx_valid (approx_done_valid),
    .approx_ready (approx_done_ready),
    .approx_tag   (approx_done_tag),
    .approx_fault (approx_done_fault),
    .approx_result(approx_done_result),
    .wr_en        (wr_en),
    .wr_lane      (wr_lane),
    .wr_tag       (wr_tag),
    .wr_fault     (wr_fault),
    .wr_result    (wr_result),
    .full         (full)
  );

  result_queue u_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .wr_lane   (wr_lane),
    .wr_tag    (wr_tag),
    .wr_fault  (wr_fault),
    .wr_result (wr_result),
    .full      (full),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_lane  (rsp_lane),
    .rsp_tag   (rsp_tag),
    .rsp_fault (rsp_fault),
    .rsp_result(rsp_result)
  );

endmodule

`default_nettype wire

/* src/req_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module req_dispatch import div_arith_pkg::*, div_bus_pkg::*; (
  input  wire                clk,
  input  wire                arst_n,
  input  wire                req_valid,
  output logic               req_ready,
  input  wire                req_approx,
  input  wire div_dividend_t req_dividend,
  input  wire div_divisor_t  req_divisor,
  output logic               exact_valid,
  input  wire                exact_ready,
  output logic               approx_valid,
  input  wire                approx_ready,
  output div_dividend_t      lane_dividend,
  output div_divisor_t       lane_divisor,
  output div_tag_t           lane_tag
);

  lane_id_e sel_lane;
  div_tag_t tag_q;

  assign sel_lane = req_approx ? LANE_APPROX : LANE_EXACT;

  // Only the chosen lane sees the request
  assign exact_valid  = req_valid && (sel_lane == LANE_EXACT);
  assign approx_valid = req_valid && (sel_lane == LANE_APPROX);
  assign req_ready    = (sel_lane == LANE_APPROX) ? approx_ready : exact_ready;

  assign lane_dividend = req_dividend;
  assign lane_divisor  = req_divisor;
  assign lane_tag      = tag_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tag_q <= '0;
    end else if (req_valid && req_ready) begin
      tag_q <= tag_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/result_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module result_arbiter import div_arith_pkg::*, div_bus_pkg::*; (
  input  wire              clk,
  input  wire              arst_n,
  input  wire              exact_valid,
  output logic             exact_ready,
  input  wire div_tag_t    exact_tag,
  input  wire              exact_fault,
  input  wire div_result_u exact_result,
  input  wire              approx_valid,
  output logic             approx_ready,
  input  wire div_tag_t    approx_tag,
  input  wire              approx_fault,
  input  wire div_result_u approx_result,
  output logic             wr_en,
  output lane_id_e         wr_lane,
  output div_tag_t         wr_tag,
  output logic             wr_fault,
  output div_result_u      wr_result,
  input  wire              full
);

  lane_id_e last_q;

  always_comb begin
    exact_ready  = 1'b0;
    approx_ready = 1'b0;
    if (!full) begin
      if (exact_valid && approx_valid) begin
        exact_ready  = (last_q == LANE_APPROX);
        approx_ready = (last_q == LANE_EXACT);
      end else begin
        exact_ready  = exact_valid;
        approx_ready = approx_valid;
      end
    end
  end

  assign wr_en     = exact_ready || approx_ready;
  assign wr_lane   = approx_ready ? LANE_APPROX : LANE_EXACT;
  assign wr_tag    = approx_ready ? approx_tag : exact_tag;
  assign wr_fault  = approx_ready ? approx_fault : exact_fault;
  assign wr_result = approx_ready ? approx_result : exact_result;

  // Starts as if the approximate lane went last, so exact wins the first tie
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_q <= LANE_APPROX;
    end else if (wr_en) begin
      last_q <= wr_lane;
    end
  end

endmodule

`default_nettype wire

/* src/result_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_service_config.svh"

module result_queue import div_arith_pkg::*, div_bus_pkg::*; (
  input  wire              clk,
  input  wire              arst_n,
  input  wire              wr_en,
  input  wire lane_id_e    wr_lane,
  input  wire div_tag_t    wr_tag,
  input  wire              wr_fault,
  input  wire div_result_u wr_result,
  output logic             full,
  output logic             rsp_valid,
  input  wire              rsp_ready,
  output lane_id_e         rsp_lane,
  output div_tag_t         rsp_tag,
  output logic             rsp_fault,
  output div_result_u      rsp_result
);

  localparam int DEPTH = `DIV_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(DEPTH);

  lane_id_e    lane_mem [DEPTH];
  div_tag_t    tag_mem [DEPTH];
  logic        fault_mem [DEPTH];
  div_result_u result_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == LAST_PTR) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full      = (count == DEPTH_CNT);
  assign rsp_valid = (count != '0);
  assign push      = wr_en && !full;
  assign pop       = rsp_valid && rsp_ready;

  assign rsp_lane   = lane_mem[rd_ptr];
  assign rsp_tag    = tag_mem[rd_ptr];
  assign rsp_fault  = fault_mem[rd_ptr];
  assign rsp_result = result_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      lane_mem[wr_ptr]   <= wr_lane;
      tag_mem[wr_ptr]    <= wr_tag;
      fault_mem[wr_ptr]  <= wr_fault;
      result_mem[wr_ptr] <= wr_result;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verification/div_service_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module div_service_assert import div_arith_pkg::*, div_bus_pkg::*; (
  input wire              clk,
  input wire              arst_n,
  input wire              rsp_valid,
  input wire              rsp_ready,
  input wire lane_id_e    rsp_lane,
  input wire div_tag_t    rsp_tag,
  input wire              rsp_fault,
  input wire div_result_u rsp_result,
  input wire              wr_en,
  input wire              full
);

  int fail_count = 0;

  // Head entry holds while the client stalls
  property p_rsp_stable;
    @(posedge clk) disable iff (!arst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_lane) && $stable(rsp_tag) &&
                                  $stable(rsp_fault) && $stable(rsp_result);
  endproperty

  property p_no_write_full;
    @(posedge clk) disable iff (!arst_n) wr_en |-> !full;
  endproperty

  property p_reset_idle;
    @(posedge clk) !arst_n |-> !rsp_valid;
  endproperty

  a_rsp_stable: assert property (p_rsp_stable) else begin
    $error("Response fields changed while stalled");
    fail_count++;
  end

  a_no_write_full: assert property (p_no_write_full) else begin
    $error("Queue write while full");
    fail_count++;
  end

  a_reset_idle: assert property (p_reset_idle) else begin
    $error("rsp_valid high during reset");
    fail_count++;
  end

endmodule

bind div_service_top div_service_assert u_assert (
  .clk       (clk),
  .arst_n    (arst_n),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp_lane  (rsp_lane),
  .rsp_tag   (rsp_tag),
  .rsp_fault (rsp_fault),
  .rsp_result(rsp_result),
  .wr_en     (wr_en),
  .full      (full)
);

`default_nettype wire

/* verification/div_service_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_service_config.svh"

module div_service_tb import div_arith_pkg::*, div_bus_pkg::*; ();

  localparam int N               = `DIV_DIVISOR_W;
  localparam int NUM_TAGS        = 2 ** `DIV_TAG_W;
  localparam int NUM_REQS        = 300;
  localparam int WATCHDOG_CYCLES = NUM_REQS * 40 + 1000;

  logic          clk;
  logic          arst_n;
  logic          req_valid;
  logic          req_ready;
  logic          req_approx;
  div_dividend_t req_dividend;
  div_divisor_t  req_divisor;
  logic          rsp_valid;
  logic          rsp_ready;
  lane_id_e      rsp_lane;
  div_tag_t      rsp_tag;
  logic          rsp_fault;
  div_result_u   rsp_result;

  // Scoreboard indexed by tag
  logic          sb_valid [NUM_TAGS];
  div_dividend_t sb_dividend [NUM_TAGS];
  div_divisor_t  sb_divisor [NUM_TAGS];
  lane_id_e      sb_lane [NUM_TAGS];
  logic          sb_fault [NUM_TAGS];
  div_result_u   sb_result [NUM_TAGS];
  div_tag_t      exact_tags[$];
  div_tag_t      approx_tags[$];
  int            outstanding = 0;
  int            approx_diffs = 0;
  int            exact_true_checks = 0;
  int            zero_faults = 0;

  div_service_top u_div_service_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_approx  (req_approx),
    .req_dividend(req_dividend),
    .req_divisor (req_divisor),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_lane    (rsp_lane),
    .rsp_tag     (rsp_tag),
    .rsp_fault   (rsp_fault),
    .rsp_result  (rsp_result)
  );

  // Bit-level model of the restoring array, cells below the depth are approximate
  function automatic div_result_u ref_divide(input div_dividend_t dividend,
                                             input div_divisor_t divisor,
                                             input int depth);
    div_result_u  res;
    div_divisor_t part;
    div_divisor_t x;
    div_divisor_t diff;
    logic         borrow;
    logic         q;
    res = '0;
    if (divisor == '0) begin
      res.fault.fault_code  = div_divisor_t'(1);
      res.fault.dividend_hi = dividend[2*N-1:N];
      return res;
    end
    part = dividend[2*N-1:N];
    for (int k = N - 1; k >= 0; k--) begin
      x      = {part[N-2:0], dividend[k]};
      borrow = 1'b0;
      for (int j = 0; j < N; j++) begin
        if (k + j < depth) begin
          diff[j] = x[j];
          borrow  = divisor[j] & (~x[j] | borrow);
        end else begin
          diff[j] = x[j] ^ divisor[j] ^ borrow;
          borrow  = (~x[j] & divisor[j]) | (~x[j] & borrow) | (divisor[j] & borrow);
        end
      end
      q                  = part[N-1] | ~borrow;
      res.qr.quotient[k] = q;
      part               = q ? diff : x;
    end
    res.qr.remainder = part;
    return res;
  endfunction

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic fail_with(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic compare_result(input string name, input div_result_u exp,
                                input div_result_u act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_lane(input string name, input lane_id_e exp, input lane_id_e act);
    if (act !== exp) begin
      $display("ERR %s lane expected %s actual %s", name, exp.name(), act.name());
      stop_run();
    end
  endtask

  task automatic compare_tag(input string name, input div_tag_t exp, input div_tag_t act);
    if (act !== exp) begin
      $display("ERR %s tag expected %0d actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s fault flag expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_with($sformatf("Timeout after %0d cycles with %0d responses still outstanding",
                        WATCHDOG_CYCLES, outstanding));
  end

  // Back-pressure in random stretches, mostly ready
  initial begin : ready_driver
    @(posedge arst_n);
    forever begin
      rsp_ready = ($urandom_range(2, 0) != 0);
      repeat ($urandom_range(12, 1)) @(posedge clk);
      #2;
    end
  end

  // Sampled mid-cycle, the pop itself happens on the next rising edge
  initial begin : compare
    div_tag_t    tag;
    div_tag_t    exp_tag;
    div_result_u true_res;
    string       name;
    forever begin
      @(negedge clk);
      if (u_div_service_top.u_assert.fail_count != 0) begin
        fail_with("A protocol assertion failed");
      end
      if (arst_n && rsp_valid && rsp_ready) begin
        tag = rsp_tag;
        if (!sb_valid[tag]) begin
          fail_with($sformatf("Response carries tag %0d which is not outstanding", tag));
        end
        name = $sformatf("%s_tag%0d%s", sb_lane[tag].name(), tag, sb_fault[tag] ? "_zero" : "");
        compare_lane(name, sb_lane[tag], rsp_lane);
        // Each lane returns its own results in order
        if (sb_lane[tag] == LANE_APPROX) begin
          exp_tag = approx_tags.pop_front();
        end else begin
          exp_tag = exact_tags.pop_front();
        end
        compare_tag(name, exp_tag, rsp_tag);
        compare_flag(name, sb_fault[tag], rsp_fault);
        compare_result(name, sb_result[tag], rsp_result);
        if (sb_fault[tag]) begin
          zero_faults++;
        end else if (sb_lane[tag] == LANE_APPROX) begin
          if (rsp_result != ref_divide(sb_dividend[tag], sb_divisor[tag], 0)) begin
            approx_diffs++;
          end
        end else if (sb_dividend[tag][2*N-1:N] < sb_divisor[tag]) begin
          true_res.qr.quotient  = div_divisor_t'(sb_dividend[tag] / sb_divisor[tag]);
          true_res.qr.remainder = div_divisor_t'(sb_dividend[tag] % sb_divisor[tag]);
          compare_result({name, "_intdiv"}, true_res, rsp_result);
          exact_true_checks++;
        end
        sb_valid[tag] = 1'b0;
        outstanding--;
      end
    end
  end

  initial begin : main
    div_tag_t tb_tag;
    void'($urandom(50537));
    arst_n       = 1'b0;
    req_valid    = 1'b0;
    req_approx   = 1'b0;
    req_dividend = '0;
    req_divisor  = '0;
    rsp_ready    = 1'b0;
    tb_tag       = '0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      sb_valid[t] = 1'b0;
    end
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // Nothing may come out before the first request
    repeat (4) begin
      @(negedge clk);
      if (rsp_valid !== 1'b0) begin
        fail_with("rsp_valid is high after reset although no request was sent");
      end
    end
    @(posedge clk);
    #2;

    for (int n = 0; n < NUM_REQS; n++) begin
      if ($urandom_range(3, 0) == 0) begin
        req_valid = 1'b0;
        repeat ($urandom_range(3, 1)) @(posedge clk);
        #2;
      end
      req_approx   = $urandom_range(1, 0);
      req_dividend = div_dividend_t'($urandom);
      req_divisor  = div_divisor_t'($urandom_range(255, 0));
      if ($urandom_range(7, 0) == 0) begin
        req_divisor = '0;
      end
      if (req_divisor != '0 && $urandom_range(1, 0) == 1) begin
        req_dividend[2*N-1:N] = div_divisor_t'($urandom_range(int'(req_divisor) - 1, 0));
      end
      req_valid = 1'b1;
      // The transfer happens on the rising edge after ready is seen high
      @(negedge clk);
      while (!req_ready) @(negedge clk);
      @(posedge clk);
      if (sb_valid[tb_tag]) begin
        fail_with($sformatf("Tag %0d was issued again while still outstanding", tb_tag));
      end
      sb_valid[tb_tag]    = 1'b1;
      sb_dividend[tb_tag] = req_dividend;
      sb_divisor[tb_tag]  = req_divisor;
      sb_lane[tb_tag]     = req_approx ? LANE_APPROX : LANE_EXACT;
      sb_fault[tb_tag]    = (req_divisor == '0);
      sb_result[tb_tag]   = ref_divide(req_dividend, req_divisor,
                                       req_approx ? `DIV_APPROX_DEPTH : 0);
      if (req_approx) begin
        approx_tags.push_back(tb_tag);
      end else begin
        exact_tags.push_back(tb_tag);
      end
      outstanding++;
      tb_tag = tb_tag + 1'b1;
      #2;
    end
    req_valid = 1'b0;

    while (outstanding != 0) @(posedge clk);
    repeat (5) @(posedge clk);

    if (outstanding == 0 && exact_tags.size() == 0 && approx_tags.size() == 0 &&
        approx_diffs > 0 && exact_true_checks > 0 && zero_faults > 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      fail_with($sformatf({"End of run checks failed: outstanding %0d, approx diffs %0d, ",
                           "integer division checks %0d, zero divisor faults %0d"},
                          outstanding, approx_diffs, exact_true_checks, zero_faults));
    end
  end

endmodule

`default_nettype wire
